// ==== build.f ====
+incdir+common
common/afifo_pkg.sv
verilog/ram_2p_bank.sv
ram_asym/ram_2p_asym.sv
verilog/fifo_ctrl.sv
verilog/asym_fifo_top.sv
test/tb_clkgen.sv
test/tb_asym_fifo.sv

// ==== common/afifo_macros.svh ====
`ifndef AFIFO_MACROS_SVH
`define AFIFO_MACROS_SVH

// push side word width
`define AF_W_DATA_W 32

// pop side byte width
`define AF_R_DATA_W 8

// byte address of the 64 byte storage
`define AF_ADDR_W 6

// one bank per byte lane
`define AF_N 4
`define AF_LANE_W 2

// row address inside one bank
`define AF_ROW_W (`AF_ADDR_W - `AF_LANE_W)

`endif

// ==== common/afifo_pkg.sv ====
`default_nettype none

`include "afifo_macros.svh"

package afifo_pkg;

   typedef struct packed {
      logic                    req;
      logic [`AF_W_DATA_W-1:0] data;
   } push_s;

   typedef struct packed {
      logic                    ack;
      logic [`AF_R_DATA_W-1:0] data;
   } pop_s;

   // byte pointer as counted or split into bank row and byte lane
   typedef union packed {
      logic [`AF_ADDR_W-1:0] flat;
      struct packed {
         logic [`AF_ROW_W-1:0]  row;
         logic [`AF_LANE_W-1:0] lane;
      } fields;
   } rd_addr_u;

   typedef struct packed {
      logic                  full;
      logic                  empty;
      logic [`AF_ADDR_W:0]   level;
   } status_s;

endpackage

`default_nettype wire

// ==== ram_asym/ram_2p_asym.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "afifo_macros.svh"

module ram_2p_asym #(
   parameter  int W_DATA_W = `AF_W_DATA_W,
   parameter  int R_DATA_W = `AF_R_DATA_W,
   parameter  int ADDR_W   = `AF_ADDR_W,
   // byte lanes per word and the row address left over
   localparam int N        = W_DATA_W / R_DATA_W,
   localparam int LANE_W   = $clog2(N),
   localparam int ROW_W    = ADDR_W - LANE_W
) (
   input  wire logic                    clk_i,

   // bank buses with lane p at slice p
   output logic      [N-1:0]            ext_mem_w_en_o,
   output logic      [ROW_W*N-1:0]      ext_mem_w_addr_o,
   output logic      [R_DATA_W*N-1:0]   ext_mem_w_data_o,
   output logic                         ext_mem_r_en_o,
   output logic      [ROW_W*N-1:0]      ext_mem_r_addr_o,
   input  wire logic [R_DATA_W*N-1:0]   ext_mem_r_data_i,

   // wide write port
   input  wire logic                    w_en_i,
   input  wire logic [ROW_W-1:0]        w_addr_i,
   input  wire logic [W_DATA_W-1:0]     w_data_i,

   // narrow read port
   input  wire logic                    r_en_i,
   input  wire afifo_pkg::rd_addr_u     r_addr_i,
   output logic      [R_DATA_W-1:0]     r_data_o
);

   // all banks see the read strobe but only one lane is kept
   assign ext_mem_r_en_o = r_en_i;

   if (W_DATA_W > R_DATA_W) begin : wide_gen

      logic [LANE_W-1:0] lane_q;

      for (genvar p = 0; p < N; p++) begin : lane_gen
         // parallel write with one byte lane per bank
         assign ext_mem_w_en_o[p]                         = w_en_i;
         assign ext_mem_w_addr_o[p*ROW_W +: ROW_W]        = w_addr_i;
         assign ext_mem_w_data_o[p*R_DATA_W +: R_DATA_W]  =
            w_data_i[p*R_DATA_W +: R_DATA_W];

         // same row to every bank
         assign ext_mem_r_addr_o[p*ROW_W +: ROW_W] = r_addr_i.fields.row;
      end

      // lane follows the bank data by one cycle
      always_ff @(posedge clk_i) begin
         if (r_en_i) begin
            lane_q <= r_addr_i.fields.lane;
         end
      end

      assign r_data_o = ext_mem_r_data_i[lane_q*R_DATA_W +: R_DATA_W];

   end else begin : equal_gen

      // one bank passed straight through
      assign ext_mem_w_en_o   = w_en_i;
      assign ext_mem_w_addr_o = w_addr_i;
      assign ext_mem_w_data_o = w_data_i;
      assign ext_mem_r_addr_o = r_addr_i.flat;
      assign r_data_o         = ext_mem_r_data_i;

   end

   // narrow write with wide read is not built here
   wide_write_only_a: assert property (
      @(posedge clk_i) W_DATA_W >= R_DATA_W
   ) else $error("ram_2p_asym: write port narrower than read port");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run the testbench into sim.log, then look for the pass line
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module tb_asym_fifo -o tb_sim &&
./obj_dir/tb_sim > sim.log 2>&1 ||
echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== test/tb_asym_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "afifo_macros.svh"

module tb_asym_fifo;

   localparam int DEPTH      = 1 << `AF_ADDR_W;
   localparam int WAIT_MAX   = 50;
   localparam int BLOCK_WAIT = 20;
   localparam logic [2:0] OP_PUSH         = 3'd0;
   localparam logic [2:0] OP_POP          = 3'd1;
   localparam logic [2:0] OP_PUSH_BLOCKED = 3'd2;
   localparam logic [2:0] OP_POP_BLOCKED  = 3'd3;
   localparam logic [2:0] OP_STATUS       = 3'd4;

   typedef struct packed {
      logic [2:0]  op;
      logic        has_exp;
      logic [31:0] data;
      logic [31:0] exp_val;
   } step_s;

   logic               clk;
   logic               reset;
   afifo_pkg::push_s   push;
   logic               push_ack;
   logic               pop_req;
   afifo_pkg::pop_s    pop;
   afifo_pkg::status_s status;

   step_s      steps [1024];
   string      names [1024];
   int         n_steps;
   logic [7:0] model [$];
   int         errors;
   int         timeouts;
   bit         aborted;
   integer     seed;

   tb_clkgen #(.PERIOD_NS(8.0), .RESET_CYCLES(16)) clkgen_i (.clk_o(clk), .reset_o(reset));

   asym_fifo_top dut_i (
      .clk_i(clk), .reset_i(reset), .push_i(push), .push_ack_o(push_ack),
      .pop_req_i(pop_req), .pop_o(pop), .status_o(status)
   );

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   // full once fewer than one word of bytes is free
   function automatic logic [31:0] model_status();
      logic full;
      logic empty;
      full  = (DEPTH - model.size()) < `AF_N;
      empty = model.size() == 0;
      return {full, empty, 7'(model.size())};
   endfunction

   task automatic wait_ack(input bit on_pop, input logic level, input int limit,
                           output bit seen);
      logic cur;
      seen = 1'b0;
      for (int n = 0; n < limit && !seen; n++) begin
         @(negedge clk);
         cur  = on_pop ? pop.ack : push_ack;
         seen = (cur === level);
      end
   endtask

   task automatic timed_out(input string name, input string what);
      timeouts++;
      aborted = 1'b1;
      $display("error %s: no %s before the timeout", name, what);
   endtask

   task automatic push_word(input string name, input logic [31:0] data, input bit blocked);
      bit seen;
      @(posedge clk);
      push.req  <= 1'b1;
      push.data <= data;
      wait_ack(1'b0, 1'b1, blocked ? BLOCK_WAIT : WAIT_MAX, seen);
      if (blocked && seen) begin
         errors++;
         $display("error %s: push was accepted while the FIFO was full", name);
      end else if (!blocked && !seen) begin
         timed_out(name, "push ack");
         return;
      end
      if (seen) begin
         for (int b = 0; b < `AF_N; b++) begin
            model.push_back(data[b*`AF_R_DATA_W +: `AF_R_DATA_W]);
         end
         check(name, model_status(), status);
      end
      @(posedge clk);
      push.req <= 1'b0;
      wait_ack(1'b0, 1'b0, WAIT_MAX, seen);
      if (!seen) begin
         timed_out(name, "fall of push ack");
      end else if (blocked) begin
         check(name, model_status(), status);
      end
   endtask

   task automatic pop_byte(input string name, input step_s st, input bit blocked);
      bit         seen;
      logic [7:0] head;
      // a request left up by an earlier step is still pending
      if (!pop_req) begin
         @(posedge clk);
         pop_req <= 1'b1;
      end
      wait_ack(1'b1, 1'b1, blocked ? BLOCK_WAIT : WAIT_MAX, seen);
      if (blocked) begin
         if (seen) begin
            errors++;
            $display("error %s: pop was acknowledged while the FIFO was empty", name);
         end
         return;
      end
      if (!seen) begin
         timed_out(name, "pop ack");
         return;
      end
      if (model.size() == 0) begin
         errors++;
         $display("error %s: pop acknowledged with no byte left in the model", name);
      end else begin
         head = model.pop_front();
         check(name, head, pop.data);
      end
      if (st.has_exp) begin
         check(name, st.exp_val, pop.data);
      end
      check(name, model_status(), status);
      @(posedge clk);
      pop_req <= 1'b0;
      wait_ack(1'b1, 1'b0, WAIT_MAX, seen);
      if (!seen) begin
         timed_out(name, "fall of pop ack");
      end
   endtask

   task automatic add_step(input logic [2:0] op, input logic [31:0] data,
                           input logic [31:0] exp_val, input bit has_exp, input string name);
      steps[n_steps] = '{op: op, has_exp: has_exp, data: data, exp_val: exp_val};
      names[n_steps] = $sformatf("%s_%0d", name, n_steps);
      n_steps++;
   endtask

   task automatic build_table();
      int          sz;
      logic [31:0] r;
      add_step(OP_STATUS, 0, {1'b0, 1'b1, 7'd0}, 1'b1, "reset");
      // one word comes back low byte first
      add_step(OP_PUSH, 32'h44332211, 0, 1'b0, "one_word");
      for (int b = 0; b < `AF_N; b++) begin
         add_step(OP_POP, 0, 8'h11 * (b + 1), 1'b1, "one_byte");
      end
      for (int w = 0; w < DEPTH / `AF_N; w++) begin
         add_step(OP_PUSH, $random(seed), 0, 1'b0, "fill");
      end
      add_step(OP_STATUS, 0, {1'b1, 1'b0, 7'(DEPTH)}, 1'b1, "full");
      r = $random(seed);
      add_step(OP_PUSH_BLOCKED, r, 0, 1'b0, "blocked");
      // full drops once a whole word is free
      for (int b = 0; b < `AF_N; b++) begin
         add_step(OP_POP, 0, 0, 1'b0, "make_room");
      end
      add_step(OP_STATUS, 0, {1'b0, 1'b0, 7'(DEPTH - `AF_N)}, 1'b1, "room");
      add_step(OP_PUSH, r, 0, 1'b0, "retry");
      for (int b = 0; b < DEPTH; b++) begin
         add_step(OP_POP, 0, 0, 1'b0, "drain");
      end
      // random mix long enough to wrap both pointers a few times
      sz = 0;
      for (int i = 0; i < 320; i++) begin
         r = $random(seed);
         if (sz == 0 || (sz <= DEPTH - `AF_N && r[1:0] == 2'b00)) begin
            add_step(OP_PUSH, $random(seed), 0, 1'b0, "mix_push");
            sz += `AF_N;
         end else begin
            add_step(OP_POP, 0, 0, 1'b0, "mix_pop");
            sz--;
         end
      end
      for (; sz > 0; sz--) begin
         add_step(OP_POP, 0, 0, 1'b0, "mix_drain");
      end
      // pending pop on an empty FIFO woken by one push
      r = $random(seed);
      add_step(OP_POP_BLOCKED, 0, 0, 1'b0, "empty_pop");
      add_step(OP_PUSH, r, 0, 1'b0, "wake");
      add_step(OP_POP, 0, r[7:0], 1'b1, "woken");
      add_step(OP_STATUS, 0, {1'b0, 1'b0, 7'd3}, 1'b1, "after_wake");
   endtask

   task automatic apply_step(input int i);
      step_s st;
      st = steps[i];
      case (st.op)
         OP_PUSH:         push_word(names[i], st.data, 1'b0);
         OP_PUSH_BLOCKED: push_word(names[i], st.data, 1'b1);
         OP_POP:          pop_byte(names[i], st, 1'b0);
         OP_POP_BLOCKED:  pop_byte(names[i], st, 1'b1);
         default: begin
            @(negedge clk);
            check(names[i], st.exp_val, 32'(status));
            check({names[i], "_acks"}, 0, {push_ack, pop.ack});
         end
      endcase
   endtask

   initial begin
      push     = '0;
      pop_req  = 1'b0;
      errors   = 0;
      timeouts = 0;
      aborted  = 1'b0;
      n_steps  = 0;
      seed     = 32'hee38b7be;
      build_table();
      for (int n = 0; n < 100 && reset !== 1'b0; n++) begin
         @(negedge clk);
      end
      if (reset !== 1'b0) begin
         timeouts++;
         aborted = 1'b1;
         $display("error: reset was never released");
      end
      for (int i = 0; i < n_steps && !aborted; i++) begin
         apply_step(i);
      end
      $display("steps %0d, errors %0d, timeouts %0d", n_steps, errors, timeouts);
      if (errors == 0 && timeouts == 0 && !aborted) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
   parameter real PERIOD_NS    = 8.0,
   parameter int  RESET_CYCLES = 16
) (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2.0) clk_o = ~clk_o;
      end
   end

   // reset held for a fixed count of rising edges
   initial begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      reset_o <= 1'b0;
   end

endmodule

`default_nettype wire

// ==== verilog/asym_fifo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "afifo_macros.svh"

module asym_fifo_top (
   input  wire logic               clk_i,
   input  wire logic               reset_i,
   input  wire afifo_pkg::push_s   push_i,
   output logic                    push_ack_o,
   input  wire logic               pop_req_i,
   output afifo_pkg::pop_s         pop_o,
   output afifo_pkg::status_s      status_o
);

   // control to adapter
   logic                           w_en;
   logic [`AF_ROW_W-1:0]           w_addr;
   logic [`AF_W_DATA_W-1:0]        w_data;
   logic                           r_en;
   afifo_pkg::rd_addr_u            r_addr;
   logic [`AF_R_DATA_W-1:0]        r_data;

   // flattened bank buses
   logic [`AF_N-1:0]               mem_w_en;
   logic [`AF_ROW_W*`AF_N-1:0]     mem_w_addr;
   logic [`AF_R_DATA_W*`AF_N-1:0]  mem_w_data;
   logic                           mem_r_en;
   logic [`AF_ROW_W*`AF_N-1:0]     mem_r_addr;
   logic [`AF_R_DATA_W*`AF_N-1:0]  mem_r_data;

   fifo_ctrl ctrl_i (
      .clk_i, .reset_i, .push_i, .push_ack_o, .pop_req_i, .pop_o, .status_o,
      .w_en_o(w_en), .w_addr_o(w_addr), .w_data_o(w_data),
      .r_en_o(r_en), .r_addr_o(r_addr), .r_data_i(r_data)
   );

   ram_2p_asym #(
      .W_DATA_W(`AF_W_DATA_W),
      .R_DATA_W(`AF_R_DATA_W),
      .ADDR_W  (`AF_ADDR_W)
   ) asym_i (
      .clk_i,
      .ext_mem_w_en_o(mem_w_en), .ext_mem_w_addr_o(mem_w_addr),
      .ext_mem_w_data_o(mem_w_data), .ext_mem_r_en_o(mem_r_en),
      .ext_mem_r_addr_o(mem_r_addr), .ext_mem_r_data_i(mem_r_data),
      .w_en_i(w_en), .w_addr_i(w_addr), .w_data_i(w_data),
      .r_en_i(r_en), .r_addr_i(r_addr), .r_data_o(r_data)
   );

   for (genvar b = 0; b < `AF_N; b++) begin : bank_gen
      ram_2p_bank #(.DATA_W(`AF_R_DATA_W), .ADDR_W(`AF_ROW_W)) bank_i (
         .clk_i,
         .w_en_i  (mem_w_en[b]),
         .w_addr_i(mem_w_addr[b*`AF_ROW_W +: `AF_ROW_W]),
         .w_data_i(mem_w_data[b*`AF_R_DATA_W +: `AF_R_DATA_W]),
         .r_en_i  (mem_r_en),
         .r_addr_i(mem_r_addr[b*`AF_ROW_W +: `AF_ROW_W]),
         .r_data_o(mem_r_data[b*`AF_R_DATA_W +: `AF_R_DATA_W])
      );
   end

endmodule

`default_nettype wire

// ==== verilog/fifo_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "afifo_macros.svh"

module fifo_ctrl (
   input  wire logic                     clk_i,
   input  wire logic                     reset_i,
   // producer side
   input  wire afifo_pkg::push_s         push_i,
   output logic                          push_ack_o,
   // consumer side
   input  wire logic                     pop_req_i,
   output afifo_pkg::pop_s               pop_o,
   output afifo_pkg::status_s            status_o,
   // storage
   output logic                          w_en_o,
   output logic      [`AF_ROW_W-1:0]     w_addr_o,
   output logic      [`AF_W_DATA_W-1:0]  w_data_o,
   output logic                          r_en_o,
   output afifo_pkg::rd_addr_u           r_addr_o,
   input  wire logic [`AF_R_DATA_W-1:0]  r_data_i
);

   localparam int DEPTH = 1 << `AF_ADDR_W;

   // pointers carry one wrap bit above the address
   logic [`AF_ROW_W:0]      wr_ptr_q;
   logic [`AF_ROW_W:0]      wr_ptr_n;
   logic [`AF_ADDR_W:0]     rd_ptr_q;
   logic [`AF_ADDR_W:0]     rd_ptr_n;
   logic [`AF_ADDR_W:0]     level_n;
   logic                    push_fire;
   logic                    pop_fire;
   logic                    push_ack_q;
   logic                    pop_ack_q;
   logic [`AF_R_DATA_W-1:0] pop_data_q;
   logic [1:0]              rd_v_q;
   afifo_pkg::status_s      status_q;

   assign push_fire = push_i.req & ~push_ack_q & ~status_q.full;
   // one pop in flight and nothing issued until ack has fallen
   assign pop_fire  = pop_req_i & ~pop_ack_q & ~(|rd_v_q) & ~status_q.empty;

   assign wr_ptr_n = wr_ptr_q + {{`AF_ROW_W{1'b0}}, push_fire};
   assign rd_ptr_n = rd_ptr_q + {{`AF_ADDR_W{1'b0}}, pop_fire};
   // words scaled to bytes minus bytes read
   assign level_n  = {wr_ptr_n, {`AF_LANE_W{1'b0}}} - rd_ptr_n;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         push_ack_q <= 1'b0;
         pop_ack_q  <= 1'b0;
         rd_v_q     <= '0;
         status_q   <= '{full: 1'b0, empty: 1'b1, level: '0};
      end else begin
         wr_ptr_q <= wr_ptr_n;
         rd_ptr_q <= rd_ptr_n;
         rd_v_q   <= {rd_v_q[0], pop_fire};

         if (push_fire) begin
            push_ack_q <= 1'b1;
         end else if (!push_i.req) begin
            push_ack_q <= 1'b0;
         end

         // bank byte is on r_data_i while rd_v_q[0]
         if (rd_v_q[0]) begin
            pop_ack_q <= 1'b1;
         end else if (!pop_req_i) begin
            pop_ack_q <= 1'b0;
         end

         status_q.level <= level_n;
         status_q.empty <= (level_n == '0);
         status_q.full  <= (level_n > (DEPTH - `AF_N));
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_v_q[0]) begin
         pop_data_q <= r_data_i;
      end
   end

   assign push_ack_o    = push_ack_q;
   assign pop_o         = '{ack: pop_ack_q, data: pop_data_q};
   assign status_o      = status_q;
   assign w_en_o        = push_fire;
   assign w_addr_o      = wr_ptr_q[`AF_ROW_W-1:0];
   assign w_data_o      = push_i.data;
   assign r_en_o        = pop_fire;
   assign r_addr_o.flat = rd_ptr_q[`AF_ADDR_W-1:0];

   no_overfill_a: assert property (@(posedge clk_i) disable iff (reset_i)
      w_en_o |=> status_o.level <= DEPTH);
   no_read_empty_a: assert property (@(posedge clk_i) disable iff (reset_i)
      r_en_o |-> rd_ptr_q != {wr_ptr_q, {`AF_LANE_W{1'b0}}});
   push_ack_req_a: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(push_ack_o) |-> $past(push_i.req));

endmodule

`default_nettype wire

// ==== verilog/ram_2p_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_2p_bank #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  wire logic              clk_i,
   // write port
   input  wire logic              w_en_i,
   input  wire logic [ADDR_W-1:0] w_addr_i,
   input  wire logic [DATA_W-1:0] w_data_i,
   // read port
   input  wire logic              r_en_i,
   input  wire logic [ADDR_W-1:0] r_addr_i,
   output logic      [DATA_W-1:0] r_data_o
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // same-address collision returns the old word
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

`default_nettype wire
